/* logic/video_params.svh */
`ifndef VIDEO_PARAMS_SVH
`define VIDEO_PARAMS_SVH

// datapath widths
`define VID_BYTE_W      8       // camera bus
`define VID_PIX_W       16      // packed rgb565 word
`define VID_CH_W        8       // per output colour channel

// line buffer
`define VID_FIFO_DEPTH  32
`define VID_FIFO_AW     5
`define VID_PREFILL     8       // one line buffered before display starts

// horizontal timing, in clocks
`define VID_H_ACTIVE    8
`define VID_H_FRONT     2
`define VID_H_SYNC      2
`define VID_H_BACK      2

// vertical timing, in lines
`define VID_V_ACTIVE    4
`define VID_V_FRONT     1
`define VID_V_SYNC      1
`define VID_V_BACK      1

`endif

/* logic/video_pkg.sv */
package video_pkg;

    // packed display pixel, red in the top bits
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } pix565_t;

    // which camera byte the packer expects next
    typedef enum logic {
        PH_HIGH = 1'b0,     // first byte of a pair
        PH_LOW  = 1'b1      // second byte completes the pixel
    } byte_phase_e;

    // raster segment, shared by the line and frame counters
    typedef enum logic [1:0] {
        SEG_SYNC   = 2'd0,
        SEG_BACK   = 2'd1,
        SEG_ACTIVE = 2'd2,
        SEG_FRONT  = 2'd3
    } tim_phase_e;

endpackage

/* logic/fifo_rd_if.sv */
`timescale 1ns/10ps
`include "video_params.svh"

interface fifo_rd_if;
    import video_pkg::*;

    logic                   rd_stb;     // one-cycle pop request
    pix565_t                rd_pixel;   // valid the cycle after rd_stb
    logic                   empty;
    logic [`VID_FIFO_AW:0]  level;      // 0 .. depth

    modport buf_side (
        input  rd_stb,
        output rd_pixel,
        output empty,
        output level
    );

    modport disp_side (
        output rd_stb,
        input  rd_pixel,
        input  empty,
        input  level
    );

endinterface

/* logic/cam_pixel_packer.sv */
`timescale 1ns/10ps
`include "video_params.svh"

module cam_pixel_packer (
    input  logic                    clk_50M,
    input  logic                    sys_rst,
    input  logic                    cam_vsync_i,
    input  logic                    cam_href_i,
    input  logic                    cam_byte_valid_i,
    input  logic [`VID_BYTE_W-1:0]  cam_data_i,
    output video_pkg::pix565_t      wr_pixel_o,
    output logic                    wr_stb_o
);
    import video_pkg::*;

    logic                   vsync_d;
    logic                   vsync_d2;
    logic                   href_d;
    logic                   valid_d;
    logic [`VID_BYTE_W-1:0] data_d;
    logic [`VID_BYTE_W-1:0] hi_byte;
    logic [`VID_PIX_W-1:0]  cam_word;
    byte_phase_e            phase;
    logic                   byte_ok;
    logic                   vsync_rise;

    // input sample stage, control bits
    always_ff @(posedge clk_50M or negedge sys_rst) begin
        if (!sys_rst) begin
            vsync_d  <= 1'b0;
            vsync_d2 <= 1'b0;
            href_d   <= 1'b0;
            valid_d  <= 1'b0;
        end else begin
            vsync_d  <= cam_vsync_i;
            vsync_d2 <= vsync_d;    // edge detect
            href_d   <= cam_href_i;
            valid_d  <= cam_byte_valid_i;
        end
    end

    always_ff @(posedge clk_50M) begin
        data_d <= cam_data_i;
    end

    assign byte_ok    = valid_d && href_d;
    assign vsync_rise = vsync_d && !vsync_d2;
    assign cam_word   = {hi_byte, data_d};  // high byte arrived first

    // byte pairing FSM
    always_ff @(posedge clk_50M or negedge sys_rst) begin
        if (!sys_rst) begin
            phase    <= PH_HIGH;
            wr_stb_o <= 1'b0;
        end else begin
            wr_stb_o <= 1'b0;
            if (vsync_rise) begin
                phase <= PH_HIGH;   // drops a leftover lone byte
            end else if (byte_ok) begin
                if (phase == PH_HIGH) begin
                    phase <= PH_LOW;
                end else begin
                    phase    <= PH_HIGH;
                    wr_stb_o <= 1'b1;
                end
            end
        end
    end

    // red and blue trade places on the way to the display
    always_ff @(posedge clk_50M) begin
        if (byte_ok && phase == PH_HIGH) begin
            hi_byte <= data_d;
        end
        if (byte_ok && phase == PH_LOW) begin
            wr_pixel_o.red   <= cam_word[4:0];
            wr_pixel_o.green <= cam_word[10:5];
            wr_pixel_o.blue  <= cam_word[15:11];
        end
    end

    // a pixel needs two bytes, so strobes are never back to back
    a_stb_spacing: assert property (
        @(posedge clk_50M) disable iff (!sys_rst) wr_stb_o |=> !wr_stb_o
    );

endmodule

/* logic/pixel_line_fifo.sv */
`timescale 1ns/10ps
`include "video_params.svh"

module pixel_line_fifo (
    input  logic                clk_50M,
    input  logic                sys_rst,
    input  video_pkg::pix565_t  wr_pixel_i,
    input  logic                wr_stb_i,
    fifo_rd_if.buf_side         rd,
    output logic                overflow_o
);
    import video_pkg::*;

    localparam int DEPTH = `VID_FIFO_DEPTH;

    pix565_t                mem [0:DEPTH-1];
    logic [`VID_FIFO_AW-1:0] wr_ptr;
    logic [`VID_FIFO_AW-1:0] rd_ptr;
    logic [`VID_FIFO_AW:0]   level_q;
    logic                    full;
    logic                    do_wr;
    logic                    do_rd;

    assign full  = (level_q == DEPTH[`VID_FIFO_AW:0]);
    assign do_wr = wr_stb_i && !full;       // camera cannot stall, so drop
    assign do_rd = rd.rd_stb && !rd.empty;  // empty read pops nothing

    assign rd.empty = (level_q == '0);
    assign rd.level = level_q;

    // pointers and level
    always_ff @(posedge clk_50M or negedge sys_rst) begin
        if (!sys_rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            level_q <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;    // depth is a power of two
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;
            endcase
        end
    end

    // storage and registered read port
    always_ff @(posedge clk_50M) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_pixel_i;
        end
        if (do_rd) begin
            rd.rd_pixel <= mem[rd_ptr];
        end
    end

    // sticky drop indicator
    always_ff @(posedge clk_50M or negedge sys_rst) begin
        if (!sys_rst) begin
            overflow_o <= 1'b0;
        end else if (wr_stb_i && full) begin
            overflow_o <= 1'b1;
        end
    end

    a_level_bound: assert property (
        @(posedge clk_50M) disable iff (!sys_rst) level_q <= DEPTH[`VID_FIFO_AW:0]
    );

endmodule

/* logic/video_timing_out.sv */
`timescale 1ns/10ps
`include "video_params.svh"

module video_timing_out (
    input  logic                    clk_50M,
    input  logic                    sys_rst,
    fifo_rd_if.disp_side            rd,
    output logic                    vs_o,
    output logic                    hs_o,
    output logic                    de_o,
    output logic [`VID_CH_W-1:0]    r_o,
    output logic [`VID_CH_W-1:0]    g_o,
    output logic [`VID_CH_W-1:0]    b_o,
    output logic                    run_o,
    output logic                    underflow_o
);
    import video_pkg::*;

    localparam int CNT_W = 4;

    tim_phase_e         h_seg;
    tim_phase_e         v_seg;
    logic [CNT_W-1:0]   h_cnt;
    logic [CNT_W-1:0]   v_cnt;
    logic               line_end;
    logic               rd_req;
    logic               hs_now;
    logic               vs_now;
    logic               de_d1;
    logic               hs_d1;
    logic               vs_d1;
    logic               miss_d1;
    pix565_t            pix;

    function automatic tim_phase_e next_seg(input tim_phase_e seg);
        case (seg)
            SEG_SYNC:   return SEG_BACK;
            SEG_BACK:   return SEG_ACTIVE;
            SEG_ACTIVE: return SEG_FRONT;
            default:    return SEG_SYNC;
        endcase
    endfunction

    // last count of each horizontal segment in clocks
    function automatic logic [CNT_W-1:0] h_last(input tim_phase_e seg);
        case (seg)
            SEG_SYNC:   return CNT_W'(`VID_H_SYNC - 1);
            SEG_BACK:   return CNT_W'(`VID_H_BACK - 1);
            SEG_ACTIVE: return CNT_W'(`VID_H_ACTIVE - 1);
            default:    return CNT_W'(`VID_H_FRONT - 1);
        endcase
    endfunction

    // last count of each vertical segment in lines
    function automatic logic [CNT_W-1:0] v_last(input tim_phase_e seg);
        case (seg)
            SEG_SYNC:   return CNT_W'(`VID_V_SYNC - 1);
            SEG_BACK:   return CNT_W'(`VID_V_BACK - 1);
            SEG_ACTIVE: return CNT_W'(`VID_V_ACTIVE - 1);
            default:    return CNT_W'(`VID_V_FRONT - 1);
        endcase
    endfunction

    assign line_end = (h_seg == SEG_FRONT) && (h_cnt == h_last(SEG_FRONT));
    assign rd_req   = run_o && (h_seg == SEG_ACTIVE) && (v_seg == SEG_ACTIVE);
    assign hs_now   = run_o && (h_seg == SEG_SYNC);
    assign vs_now   = run_o && (v_seg == SEG_SYNC);
    assign pix      = rd.rd_pixel;

    assign rd.rd_stb = rd_req;  // one cycle ahead of the pixel slot

    // start once a line is buffered, then free-run the raster
    always_ff @(posedge clk_50M or negedge sys_rst) begin
        if (!sys_rst) begin
            run_o <= 1'b0;
            h_seg <= SEG_SYNC;
            h_cnt <= '0;
            v_seg <= SEG_SYNC;
            v_cnt <= '0;
        end else if (!run_o) begin
            run_o <= (rd.level >= `VID_PREFILL);
        end else begin
            if (h_cnt == h_last(h_seg)) begin
                h_cnt <= '0;
                h_seg <= next_seg(h_seg);
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
            if (line_end) begin
                if (v_cnt == v_last(v_seg)) begin
                    v_cnt <= '0;
                    v_seg <= next_seg(v_seg);
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end
        end
    end

    // two-stage delay keeps syncs lined up with fifo read data
    always_ff @(posedge clk_50M or negedge sys_rst) begin
        if (!sys_rst) begin
            de_d1       <= 1'b0;
            hs_d1       <= 1'b0;
            vs_d1       <= 1'b0;
            miss_d1     <= 1'b0;
            de_o        <= 1'b0;
            hs_o        <= 1'b0;
            vs_o        <= 1'b0;
            underflow_o <= 1'b0;
        end else begin
            de_d1   <= rd_req;
            hs_d1   <= hs_now;
            vs_d1   <= vs_now;
            miss_d1 <= rd_req && rd.empty;  // nothing was popped
            de_o    <= de_d1;
            hs_o    <= hs_d1;
            vs_o    <= vs_d1;
            if (rd_req && rd.empty) begin
                underflow_o <= 1'b1;
            end
        end
    end

    // 565 to 888 with zero fill in the low bits
    always_ff @(posedge clk_50M) begin
        if (de_d1 && !miss_d1) begin
            r_o <= {pix.red,   {(`VID_CH_W - 5){1'b0}}};
            g_o <= {pix.green, {(`VID_CH_W - 6){1'b0}}};
            b_o <= {pix.blue,  {(`VID_CH_W - 5){1'b0}}};
        end else begin
            r_o <= '0;  // blanking or starved read
            g_o <= '0;
            b_o <= '0;
        end
    end

    a_de_hs_excl: assert property (
        @(posedge clk_50M) disable iff (!sys_rst) !(de_o && hs_o)
    );

endmodule

/* logic/cam_video_top.sv */
`timescale 1ns/10ps
`include "video_params.svh"

module cam_video_top (
    input  logic                    clk_50M,
    input  logic                    sys_rst,
    input  logic                    cam_vsync_i,
    input  logic                    cam_href_i,
    input  logic                    cam_byte_valid_i,
    input  logic [`VID_BYTE_W-1:0]  cam_data_i,
    output logic                    vs_o,
    output logic                    hs_o,
    output logic                    de_o,
    output logic [`VID_CH_W-1:0]    r_o,
    output logic [`VID_CH_W-1:0]    g_o,
    output logic [`VID_CH_W-1:0]    b_o,
    output logic                    video_run_o,
    output logic                    fifo_overflow_o,
    output logic                    fifo_underflow_o
);
    import video_pkg::*;

    pix565_t    wr_pixel;   // packer to line buffer
    logic       wr_stb;

    fifo_rd_if  rd_bus ();

    cam_pixel_packer u_packer (
        .clk_50M            (clk_50M            ),
        .sys_rst            (sys_rst            ),
        .cam_vsync_i        (cam_vsync_i        ),
        .cam_href_i         (cam_href_i         ),
        .cam_byte_valid_i   (cam_byte_valid_i   ),
        .cam_data_i         (cam_data_i         ),
        .wr_pixel_o         (wr_pixel           ),
        .wr_stb_o           (wr_stb             )
    );

    pixel_line_fifo u_fifo (
        .clk_50M            (clk_50M            ),
        .sys_rst            (sys_rst            ),
        .wr_pixel_i         (wr_pixel           ),
        .wr_stb_i           (wr_stb             ),
        .rd                 (rd_bus.buf_side    ),
        .overflow_o         (fifo_overflow_o    )
    );

    video_timing_out u_timing (
        .clk_50M            (clk_50M            ),
        .sys_rst            (sys_rst            ),
        .rd                 (rd_bus.disp_side   ),
        .vs_o               (vs_o               ),
        .hs_o               (hs_o               ),
        .de_o               (de_o               ),
        .r_o                (r_o                ),
        .g_o                (g_o                ),
        .b_o                (b_o                ),
        .run_o              (video_run_o        ),
        .underflow_o        (fifo_underflow_o   )
    );

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
    input  logic rst_req_i,
    output logic clk_50M,
    output logic sys_rst
);

    initial begin
        clk_50M = 1'b0;
        forever #10 clk_50M = ~clk_50M;     // 20 ns period
    end

    // power-on reset, then again on every request
    initial begin
        sys_rst = 1'b0;
        repeat (3) @(posedge clk_50M);
        @(negedge clk_50M);
        sys_rst = 1'b1;
        forever begin
            @(posedge rst_req_i);
            @(negedge clk_50M);
            sys_rst = 1'b0;
            repeat (3) @(posedge clk_50M);
            @(negedge clk_50M);
            sys_rst = 1'b1;
        end
    end

endmodule

/* tests/tb_cam_video.sv */
`timescale 1ns/10ps
`include "video_params.svh"

module tb_cam_video;

    localparam int WAIT_LIMIT  = 2000;              // clocks allowed per wait
    localparam int LINE_PIX    = `VID_H_ACTIVE;
    localparam int FRAME_LINES = `VID_V_ACTIVE;
    localparam int OVF_LINES   = 12;                // outruns one frame of draining
    localparam int SEL_RUN     = 0;
    localparam int SEL_OVF     = 1;
    localparam int SEL_UDF     = 2;

    logic                   clk_50M;
    logic                   sys_rst;
    logic                   rst_req;
    logic                   cam_vsync;
    logic                   cam_href;
    logic                   cam_byte_valid;
    logic [`VID_BYTE_W-1:0] cam_data;
    logic                   vs;
    logic                   hs;
    logic                   de;
    logic [`VID_CH_W-1:0]   r;
    logic [`VID_CH_W-1:0]   g;
    logic [`VID_CH_W-1:0]   b;
    logic                   video_run;
    logic                   fifo_overflow;
    logic                   fifo_underflow;

    logic [23:0]            obs_q[$];       // every pixel shown with de high
    logic [23:0]            exp_q[$];       // model, one entry per camera pixel
    logic [15:0]            line_buf[$];    // camera words of the next line
    int                     checked;
    int                     value_errs;
    int                     other_errs;
    integer                 seed;

    tb_clock_gen u_clk (
        .rst_req_i  (rst_req),
        .clk_50M    (clk_50M),
        .sys_rst    (sys_rst)
    );

    cam_video_top i_dut (
        .clk_50M            (clk_50M),
        .sys_rst            (sys_rst),
        .cam_vsync_i        (cam_vsync),
        .cam_href_i         (cam_href),
        .cam_byte_valid_i   (cam_byte_valid),
        .cam_data_i         (cam_data),
        .vs_o               (vs),
        .hs_o               (hs),
        .de_o               (de),
        .r_o                (r),
        .g_o                (g),
        .b_o                (b),
        .video_run_o        (video_run),
        .fifo_overflow_o    (fifo_overflow),
        .fifo_underflow_o   (fifo_underflow)
    );

    always @(negedge clk_50M) begin
        if (sys_rst && de) begin
            obs_q.push_back({r, g, b});
        end
    end

    // display red takes camera bits 4:0, blue takes 15:11
    function automatic logic [23:0] expect_rgb(input logic [15:0] word);
        logic [7:0] rr;
        logic [7:0] gg;
        logic [7:0] bb;
        rr = {word[4:0], 3'b000};
        gg = {word[10:5], 2'b00};
        bb = {word[15:11], 3'b000};
        return {rr, gg, bb};
    endfunction

    function automatic logic status_bit(input int which);
        case (which)
            SEL_RUN: return video_run;
            SEL_OVF: return fifo_overflow;
            default: return fifo_underflow;
        endcase
    endfunction

    task automatic send_byte(input logic [7:0] val);
        @(negedge clk_50M);
        cam_href       = 1'b1;
        cam_byte_valid = 1'b1;
        cam_data       = val;
    endtask

    task automatic send_pixel(input logic [15:0] word);
        send_byte(word[15:8]);     // high byte first
        send_byte(word[7:0]);
        exp_q.push_back(expect_rgb(word));
    endtask

    task automatic end_burst();
        @(negedge clk_50M);
        cam_href       = 1'b0;
        cam_byte_valid = 1'b0;
        cam_data       = '0;
    endtask

    task automatic fill_random_line();
        logic [31:0] rnd;
        int          i;
        line_buf.delete();
        for (i = 0; i < LINE_PIX; i++) begin
            rnd = $random(seed);
            line_buf.push_back(rnd[15:0]);
        end
    endtask

    // href stays high afterwards, so lines can run back to back
    task automatic drive_line();
        int i;
        for (i = 0; i < line_buf.size(); i++) begin
            send_pixel(line_buf[i]);
        end
    endtask

    task automatic drive_random_lines(input int count);
        int l;
        for (l = 0; l < count; l++) begin
            fill_random_line();
            drive_line();
        end
        end_burst();
    endtask

    task automatic wait_status(input int which, input string what);
        int n;
        n = 0;
        while (!status_bit(which) && n < WAIT_LIMIT) begin
            @(negedge clk_50M);
            n++;
        end
        if (!status_bit(which)) begin
            $display("timeout: %s did not happen", what);
            other_errs++;
        end
    endtask

    task automatic wait_reset_level(input logic level, input string what);
        int n;
        n = 0;
        while (sys_rst !== level && n < WAIT_LIMIT) begin
            @(negedge clk_50M);
            n++;
        end
        if (sys_rst !== level) begin
            $display("timeout: reset never %s", what);
            other_errs++;
        end
    endtask

    task automatic wait_pixels(input int count, input string what);
        int n;
        n = 0;
        while (obs_q.size() < count && n < WAIT_LIMIT) begin
            @(posedge clk_50M);
            n++;
        end
        if (obs_q.size() < count) begin
            $display("timeout: %s, only %0d of %0d pixels shown", what, obs_q.size(), count);
            other_errs++;
        end
    endtask

    // frame start seen on the delayed vsync output
    task automatic wait_vs_rise();
        int   n;
        logic seen_low;
        logic done;
        n        = 0;
        seen_low = 1'b0;
        done     = 1'b0;
        while (!done && n < WAIT_LIMIT) begin
            @(negedge clk_50M);
            n++;
            if (!vs) begin
                seen_low = 1'b1;
            end else if (seen_low) begin
                done = 1'b1;
            end
        end
        if (!done) begin
            $display("timeout: no new display frame started");
            other_errs++;
        end
    endtask

    task automatic compare_upto(input int upto, input string what);
        int i;
        for (i = checked; i < upto && i < obs_q.size() && i < exp_q.size(); i++) begin
            if (obs_q[i] !== exp_q[i]) begin
                $display("ERR %0t: %s pixel %0d is %h, expected %h",
                         $time, what, i, obs_q[i], exp_q[i]);
                value_errs++;
            end
        end
        checked = upto;
    endtask

    task automatic test_reset_state();
        int i;
        for (i = 0; i < 40; i++) begin
            @(negedge clk_50M);
            if (de || hs || vs || video_run || fifo_overflow || fifo_underflow) begin
                $display("ERR %0t: output active with no camera data, cycle %0d", $time, i);
                value_errs++;
            end
        end
    endtask

    task automatic test_packing();
        line_buf.delete();
        line_buf.push_back(16'hF800);   // pure fields
        line_buf.push_back(16'h07E0);
        line_buf.push_back(16'h001F);
        line_buf.push_back(16'hFFFF);
        line_buf.push_back(16'h0000);
        line_buf.push_back(16'hA5C3);
        line_buf.push_back(16'h1234);
        line_buf.push_back(16'h8001);
        drive_line();
        fill_random_line();
        drive_line();
        end_burst();
        wait_status(SEL_RUN, "video_run_o rise");
        drive_random_lines(FRAME_LINES - 2);    // rest of the first frame
        wait_pixels(LINE_PIX, "first display line");
        compare_upto(LINE_PIX, "first line");
    endtask

    task automatic test_sustained();
        wait_vs_rise();
        drive_random_lines(FRAME_LINES);
        wait_pixels(exp_q.size(), "sustained frame");
        compare_upto(exp_q.size(), "sustained");
        @(negedge clk_50M);
        if (fifo_overflow || fifo_underflow) begin
            $display("ERR %0t: flag set during paced stream, ovf %b udf %b",
                     $time, fifo_overflow, fifo_underflow);
            value_errs++;
        end
    endtask

    task automatic test_vsync_align();
        logic [31:0] rnd;
        wait_vs_rise();
        rnd = $random(seed);
        send_byte(rnd[7:0]);            // lone byte, must be dropped
        end_burst();
        @(negedge clk_50M);
        cam_vsync = 1'b1;
        @(negedge clk_50M);
        @(negedge clk_50M);
        cam_vsync = 1'b0;
        drive_random_lines(FRAME_LINES);
        wait_pixels(exp_q.size(), "frame after vsync");
        compare_upto(exp_q.size(), "after vsync");
        @(negedge clk_50M);
        if (fifo_overflow || fifo_underflow) begin
            $display("ERR %0t: flag set around vsync, ovf %b udf %b",
                     $time, fifo_overflow, fifo_underflow);
            value_errs++;
        end
    endtask

    task automatic test_underflow();
        int base;
        int i;
        base = exp_q.size();
        wait_status(SEL_UDF, "fifo_underflow_o rise");
        wait_pixels(base + LINE_PIX, "starved line");
        for (i = base; i < base + LINE_PIX && i < obs_q.size(); i++) begin
            if (obs_q[i] !== 24'h0) begin
                $display("ERR %0t: starved pixel %0d is %h, expected black", $time, i, obs_q[i]);
                value_errs++;
            end
        end
        if (fifo_overflow) begin
            $display("ERR %0t: fifo_overflow_o set while starved", $time);
            value_errs++;
        end
    endtask

    task automatic test_overflow();
        rst_req = 1'b1;
        wait_reset_level(1'b0, "asserted");
        rst_req = 1'b0;
        wait_reset_level(1'b1, "released");
        if (fifo_overflow || fifo_underflow || video_run) begin
            $display("ERR %0t: status not cleared by reset", $time);
            value_errs++;
        end
        drive_random_lines(OVF_LINES);  // one unbroken burst
        wait_status(SEL_OVF, "fifo_overflow_o rise");
    endtask

    initial begin
        seed           = 29659;
        rst_req        = 1'b0;
        cam_vsync      = 1'b0;
        cam_href       = 1'b0;
        cam_byte_valid = 1'b0;
        cam_data       = '0;
        checked        = 0;
        value_errs     = 0;
        other_errs     = 0;
        wait_reset_level(1'b1, "released");
        test_reset_state();
        test_packing();
        test_sustained();
        test_vsync_align();
        test_underflow();
        test_overflow();
        $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* cam_video.f */
+incdir+logic
logic/video_pkg.sv
logic/fifo_rd_if.sv
logic/cam_pixel_packer.sv
logic/pixel_line_fifo.sv
logic/video_timing_out.sv
logic/cam_video_top.sv
tests/tb_clock_gen.sv
tests/tb_cam_video.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_cam_video -f cam_video.f

out=$(./obj_dir/Vtb_cam_video)
echo "$out"

if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
